// ==== hdl/router_pkg.sv ====
`default_nettype none

package router_pkg;

    //////////////////////////////////////////////////
    // Router geometry
    //////////////////////////////////////////////////

    // Five ports: local plus the four mesh neighbours
    localparam int NUM_PORTS = 5;

    // One flit is one whole packet
    localparam int FLIT_WIDTH = 16;

    // Mesh coordinates are 2 bits, so up to a 4x4 mesh
    localparam int COORD_WIDTH = 2;

    // Whatever is left after both coordinates
    localparam int PAYLOAD_WIDTH = FLIT_WIDTH - 2 * COORD_WIDTH;

    //////////////////////////////////////////////////
    // Directions and flit layout
    //////////////////////////////////////////////////

    // Port index and routing result share one encoding
    typedef enum logic [2:0]
    {
        DIR_LOCAL = 3'd0,
        DIR_NORTH = 3'd1,
        DIR_EAST  = 3'd2,
        DIR_SOUTH = 3'd3,
        DIR_WEST  = 3'd4
    } port_dir_t;

    // Destination coordinates sit in the top bits
    typedef struct packed
    {
        logic [COORD_WIDTH-1:0]   dest_x;
        logic [COORD_WIDTH-1:0]   dest_y;
        logic [PAYLOAD_WIDTH-1:0] payload;
    } flit_t;

endpackage

`default_nettype wire

// ==== hdl/port_req_if.sv ====
`timescale 1ns/10ps
`default_nettype none

// One bundle per input port, shared by all five output ports
interface port_req_if
    import router_pkg::*;
();

    // Head register holds a flit
    logic                 req_valid;
    // Routed direction of the head flit
    port_dir_t            req_dir;
    // The head flit itself
    flit_t                flit;
    // Bit j comes from output port j only
    wire [NUM_PORTS-1:0]  granted;

    // Input unit side
    modport requester
    (
        output req_valid,
        output req_dir,
        output flit,
        input  granted
    );

    // Output port side, each one drives only its own grant bit
    modport server
    (
        input  req_valid,
        input  req_dir,
        input  flit,
        output granted
    );

endinterface

`default_nettype wire

// ==== hdl/flit_fifo.sv ====
`timescale 1ns/10ps
`default_nettype none

module flit_fifo
    import router_pkg::*;
#(
    parameter int DEPTH = 8
)
(
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     wr_en,
    input  wire                     rd_en,
    input  wire flit_t              fifo_in,
    output flit_t                   fifo_out,
    output logic                    empty,
    output logic                    full,
    output logic [$clog2(DEPTH):0]  fifo_counter
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = PTR_W + 1;
    localparam logic [CNT_W-1:0] DEPTH_CNT = CNT_W'(DEPTH);

    // Pointers wrap on their own since DEPTH is a power of two
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;

    // Storage
    flit_t fifo_mem [DEPTH];

    // Accepted operations only
    logic wr_ok;
    logic rd_ok;

    assign empty = (fifo_counter == '0);
    assign full  = (fifo_counter == DEPTH_CNT);

    // Write while full and read while empty fall through silently
    assign wr_ok = wr_en && !full;
    assign rd_ok = rd_en && !empty;

    //////////////////////////////////////////////////
    // Occupancy and pointers
    //////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst_n)
    begin
        if (rst_n)
        begin
            fifo_counter <= '0;
            wr_ptr       <= '0;
            rd_ptr       <= '0;
        end
        else
        begin
            // Read plus write leaves the level alone
            case ({wr_ok, rd_ok})
                2'b10:   fifo_counter <= fifo_counter + 1'b1;
                2'b01:   fifo_counter <= fifo_counter - 1'b1;
                default: fifo_counter <= fifo_counter;
            endcase

            if (wr_ok)
                wr_ptr <= wr_ptr + 1'b1;

            if (rd_ok)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // Data path
    //////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (wr_ok)
            fifo_mem[wr_ptr] <= fifo_in;
    end

    // Registered read port, holds its value between reads
    always_ff @(posedge clk or posedge rst_n)
    begin
        if (rst_n)
            fifo_out <= '0;
        else if (rd_ok)
            fifo_out <= fifo_mem[rd_ptr];
    end

    // Level bound
    a_cnt_bound: assert property (@(posedge clk) disable iff (rst_n)
        fifo_counter <= DEPTH_CNT)
        else $error("fifo_counter %0d above DEPTH", fifo_counter);

    // No accepted access, no level change
    a_cnt_idle: assert property (@(posedge clk) disable iff (rst_n)
        !(wr_ok || rd_ok) |=> $stable(fifo_counter))
        else $error("fifo_counter moved without an accepted access");

endmodule

`default_nettype wire

// ==== hdl/input_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module input_unit
    import router_pkg::*;
#(
    parameter int DEPTH    = 8,
    parameter int ROUTER_X = 1,
    parameter int ROUTER_Y = 1
)
(
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire flit_t          in_flit,
    input  wire                 in_valid,
    output logic                in_full,
    port_req_if.requester       req
);

    localparam logic [COORD_WIDTH-1:0] MY_X = COORD_WIDTH'(ROUTER_X);
    localparam logic [COORD_WIDTH-1:0] MY_Y = COORD_WIDTH'(ROUTER_Y);

    // Buffer side
    flit_t                   buf_out;
    logic                    buf_empty;
    logic                    rd_en;

    // buf_out holds a flit not yet moved into the head
    logic                    rd_pend;

    // Head stage
    flit_t                   head_flit;
    logic                    head_valid;
    logic                    head_free;
    logic                    granted_any;
    port_dir_t               route;

    //////////////////////////////////////////////////
    // Flit buffer
    //////////////////////////////////////////////////

    flit_fifo #(
        .DEPTH        (DEPTH)
    ) buf_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .wr_en        (in_valid),
        .rd_en        (rd_en),
        .fifo_in      (in_flit),
        .fifo_out     (buf_out),
        .empty        (buf_empty),
        .full         (in_full),
        .fifo_counter ()
    );

    //////////////////////////////////////////////////
    // Head register
    //////////////////////////////////////////////////

    // At most one output grants a given head
    assign granted_any = |req.granted;

    // Slot frees up when empty or leaving this cycle
    assign head_free = !head_valid || granted_any;
    assign rd_en     = !buf_empty && head_free;

    always_ff @(posedge clk or posedge rst_n)
    begin
        if (rst_n)
        begin
            rd_pend    <= 1'b0;
            head_valid <= 1'b0;
            head_flit  <= '0;
        end
        else
        begin
            // New flit lands in buf_out, or the old one moved on
            if (rd_en)
                rd_pend <= 1'b1;
            else if (head_free)
                rd_pend <= 1'b0;

            // Refill from the buffer output, empty if nothing pending
            if (head_free)
            begin
                head_valid <= rd_pend;
                head_flit  <= buf_out;
            end
        end
    end

    //////////////////////////////////////////////////
    // XY routing, X first then Y
    //////////////////////////////////////////////////

    always_comb
    begin
        if (head_flit.dest_x > MY_X)
            route = DIR_EAST;
        else if (head_flit.dest_x < MY_X)
            route = DIR_WEST;
        else if (head_flit.dest_y > MY_Y)
            route = DIR_NORTH;
        else if (head_flit.dest_y < MY_Y)
            route = DIR_SOUTH;
        else
            route = DIR_LOCAL;
    end

    assign req.req_valid = head_valid;
    assign req.req_dir   = route;
    assign req.flit      = head_flit;

    // Outputs only grant a standing request
    a_grant_needs_req: assert property (@(posedge clk) disable iff (rst_n)
        !req.req_valid |-> (req.granted == '0))
        else $error("granted %b without req_valid", req.granted);

endmodule

`default_nettype wire

// ==== hdl/output_port.sv ====
`timescale 1ns/10ps
`default_nettype none

module output_port
    import router_pkg::*;
#(
    parameter int PORT_ID = 0
)
(
    input  wire         clk,
    input  wire         rst_n,
    port_req_if.server  reqs [NUM_PORTS],
    output flit_t       out_flit,
    output logic        out_valid
);

    localparam int        IDX_W  = $clog2(NUM_PORTS);
    localparam port_dir_t MY_DIR = port_dir_t'(PORT_ID);

    // Inputs whose head wants this port
    logic [NUM_PORTS-1:0] req_vec;
    flit_t                cand_flit [NUM_PORTS];

    // Arbiter
    logic [IDX_W-1:0]     rr_ptr;
    logic [IDX_W-1:0]     winner;
    logic                 grant_vld;
    logic [NUM_PORTS-1:0] grant_vec;

    //////////////////////////////////////////////////
    // Request collection and grant return
    //////////////////////////////////////////////////

    for (genvar i = 0; i < NUM_PORTS; i++)
    begin : g_req
        assign req_vec[i]   = reqs[i].req_valid && (reqs[i].req_dir == MY_DIR);
        assign cand_flit[i] = reqs[i].flit;
        // This port owns only its own bit
        assign reqs[i].granted[PORT_ID] = grant_vec[i];
    end

    //////////////////////////////////////////////////
    // Round-robin pick
    //////////////////////////////////////////////////

    // First requester at or after the pointer, wrapping at NUM_PORTS
    always_comb
    begin
        int idx;
        grant_vld = 1'b0;
        winner    = '0;
        for (int off = 0; off < NUM_PORTS; off++)
        begin
            idx = int'(rr_ptr) + off;
            if (idx >= NUM_PORTS)
                idx = idx - NUM_PORTS;
            if (!grant_vld && req_vec[idx])
            begin
                grant_vld = 1'b1;
                winner    = IDX_W'(idx);
            end
        end
    end

    always_comb
    begin
        grant_vec = '0;
        if (grant_vld)
            grant_vec[winner] = 1'b1;
    end

    // Winner drops to lowest priority next time
    always_ff @(posedge clk or posedge rst_n)
    begin
        if (rst_n)
            rr_ptr <= '0;
        else if (grant_vld)
            rr_ptr <= (winner == IDX_W'(NUM_PORTS - 1)) ? '0 : winner + 1'b1;
    end

    //////////////////////////////////////////////////
    // Output register
    //////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst_n)
    begin
        if (rst_n)
            out_valid <= 1'b0;
        else
            out_valid <= grant_vld;
    end

    always_ff @(posedge clk)
    begin
        if (grant_vld)
            out_flit <= cand_flit[winner];
    end

    // Single winner per cycle
    a_one_grant: assert property (@(posedge clk) disable iff (rst_n)
        $onehot0(grant_vec))
        else $error("port %0d granted %b", PORT_ID, grant_vec);

endmodule

`default_nettype wire

// ==== hdl/router_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module router_top
    import router_pkg::*;
#(
    parameter int DEPTH    = 8,
    parameter int ROUTER_X = 1,
    parameter int ROUTER_Y = 1
)
(
    input  wire                          clk,
    input  wire                          rst_n,
    // Index k is direction k on every bus
    input  wire flit_t [NUM_PORTS-1:0]   in_flit,
    input  wire        [NUM_PORTS-1:0]   in_valid,
    output logic       [NUM_PORTS-1:0]   in_full,
    output flit_t      [NUM_PORTS-1:0]   out_flit,
    output logic       [NUM_PORTS-1:0]   out_valid
);

    // One request bundle per input port
    port_req_if req_if [NUM_PORTS] ();

    //////////////////////////////////////////////////
    // Input side
    //////////////////////////////////////////////////

    for (genvar k = 0; k < NUM_PORTS; k++)
    begin : g_in
        input_unit #(
            .DEPTH    (DEPTH),
            .ROUTER_X (ROUTER_X),
            .ROUTER_Y (ROUTER_Y)
        ) in_i (
            .clk      (clk),
            .rst_n    (rst_n),
            .in_flit  (in_flit[k]),
            .in_valid (in_valid[k]),
            .in_full  (in_full[k]),
            .req      (req_if[k])
        );
    end

    //////////////////////////////////////////////////
    // Output side
    //////////////////////////////////////////////////

    // Every output sees all five requests and drives bit j of each grant
    for (genvar j = 0; j < NUM_PORTS; j++)
    begin : g_out
        output_port #(
            .PORT_ID   (j)
        ) out_i (
            .clk       (clk),
            .rst_n     (rst_n),
            .reqs      (req_if),
            .out_flit  (out_flit[j]),
            .out_valid (out_valid[j])
        );
    end

endmodule

`default_nettype wire

// ==== test/router_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module router_tb
    import router_pkg::*;
();

    // Mesh position of the DUT, same as the top-level defaults
    localparam logic [COORD_WIDTH-1:0] MY_X = 2'd1;
    localparam logic [COORD_WIDTH-1:0] MY_Y = 2'd1;
    localparam int DRAIN_LIMIT = 2000;

    logic                        clk;
    logic                        rst_n;
    flit_t [NUM_PORTS-1:0]       in_flit;
    logic  [NUM_PORTS-1:0]       in_valid;
    logic  [NUM_PORTS-1:0]       in_full;
    flit_t [NUM_PORTS-1:0]       out_flit;
    logic  [NUM_PORTS-1:0]       out_valid;

    // Scoreboard, one queue per source and expected output
    flit_t       exp_q [NUM_PORTS][NUM_PORTS][$];
    int          pending;
    // Arrival log: output, source and edge of each delivered flit
    int          arr_port [$];
    int          arr_src [$];
    int          arr_cyc [$];

    int          cyc = 0;
    int          acc_cyc;
    logic        full_seen;
    logic [8:0]  seq [NUM_PORTS];
    logic [31:0] lfsr;
    int          checks;
    int          errors;
    int          err_mark;

    router_top dut_i
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_flit   (in_flit),
        .in_valid  (in_valid),
        .in_full   (in_full),
        .out_flit  (out_flit),
        .out_valid (out_valid)
    );

    always #5 clk = ~clk;

    always @(posedge clk)
        cyc <= cyc + 1;

    //////////////////////////////////////////////////
    // Reference model and random source
    //////////////////////////////////////////////////

    // X first, then Y, local when both match
    function automatic port_dir_t xy_route(input logic [1:0] dx, input logic [1:0] dy);
        if (dx > MY_X)
            return DIR_EAST;
        if (dx < MY_X)
            return DIR_WEST;
        if (dy > MY_Y)
            return DIR_NORTH;
        if (dy < MY_Y)
            return DIR_SOUTH;
        return DIR_LOCAL;
    endfunction

    // Taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One step per bit taken
    task automatic draw(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp)
        else
        begin
            $display("error %0t %s got %0h expected %0h", $time, name, got, exp);
            errors++;
        end
    endtask

    //////////////////////////////////////////////////
    // Acceptance tracker and output monitor
    //////////////////////////////////////////////////

    // Values read here are the ones the DUT sees at this edge
    always @(posedge clk)
    begin
        port_dir_t d;
        if (!rst_n)
        begin
            for (int k = 0; k < NUM_PORTS; k++)
            begin
                if (in_full[k])
                    full_seen = 1'b1;
                if (in_valid[k] && !in_full[k])
                begin
                    d = xy_route(in_flit[k].dest_x, in_flit[k].dest_y);
                    exp_q[k][int'(d)].push_back(in_flit[k]);
                    pending++;
                    acc_cyc = cyc;
                end
            end
        end
    end

    // out_valid set at edge n shows up here at edge n+1
    always @(posedge clk)
    begin
        flit_t got;
        int    src;
        if (!rst_n)
        begin
            for (int j = 0; j < NUM_PORTS; j++)
            begin
                if (out_valid[j])
                begin
                    got = out_flit[j];
                    src = int'(got.payload[PAYLOAD_WIDTH-1 -: 3]);
                    checks++;
                    assert (src < NUM_PORTS && exp_q[src][j].size() > 0)
                    else
                    begin
                        $display("%0t: output %0d delivered a flit from input %0d that was not expected",
                            $time, j, src);
                        errors++;
                    end
                    if (src < NUM_PORTS && exp_q[src][j].size() > 0)
                    begin
                        check_eq($sformatf("out_flit[%0d]", j), got, exp_q[src][j].pop_front());
                        pending--;
                    end
                    arr_port.push_back(j);
                    arr_src.push_back(src);
                    arr_cyc.push_back(cyc - 1);
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Stimulus helpers
    //////////////////////////////////////////////////

    // Call right after a rising edge
    task automatic drive_flit(input int k, input logic [1:0] dx, input logic [1:0] dy);
        flit_t f;
        f.dest_x    = dx;
        f.dest_y    = dy;
        f.payload   = {3'(k), seq[k]};
        in_flit[k]  <= f;
        in_valid[k] <= 1'b1;
        seq[k]      = seq[k] + 1'b1;
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst_n <= 1'b1;
        for (int s = 0; s < NUM_PORTS; s++)
            for (int d = 0; d < NUM_PORTS; d++)
                exp_q[s][d].delete();
        pending = 0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b0;
    endtask

    task automatic clear_log();
        arr_port.delete();
        arr_src.delete();
        arr_cyc.delete();
    endtask

    // Checked at the falling edge, away from the scoreboard updates
    task automatic wait_drain(input int limit);
        int n;
        n = 0;
        @(negedge clk);
        while (pending != 0 && n < limit)
        begin
            @(negedge clk);
            n++;
        end
        checks++;
        assert (pending == 0)
        else
        begin
            $display("%0t: timeout, %0d accepted flits never came out after %0d cycles",
                $time, pending, limit);
            errors++;
        end
    endtask

    task automatic report(input int num, input string name);
        if (errors == err_mark)
            $display("case %0d %s: ok", num, name);
        else
            $display("case %0d %s: %0d errors", num, name, errors - err_mark);
        err_mark = errors;
    endtask

    //////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////

    task automatic single_flits();
        logic [1:0] dxs [NUM_PORTS] = '{2'd1, 2'd1, 2'd2, 2'd1, 2'd0};
        logic [1:0] dys [NUM_PORTS] = '{2'd1, 2'd2, 2'd1, 2'd0, 2'd1};
        for (int s = 0; s < NUM_PORTS; s++)
        begin
            for (int d = 0; d < NUM_PORTS; d++)
            begin
                clear_log();
                @(posedge clk);
                drive_flit(s, dxs[d], dys[d]);
                @(posedge clk);
                in_valid <= '0;
                wait_drain(50);
                check_eq("arrival count", arr_port.size(), 1);
                if (arr_port.size() == 1)
                begin
                    check_eq("out port", arr_port[0], int'(xy_route(dxs[d], dys[d])));
                    check_eq("arrival cycle", arr_cyc[0], acc_cyc + 3);
                end
            end
        end
    endtask

    task automatic random_traffic(input int n_cycles);
        logic [31:0] r;
        int          gap [NUM_PORTS];
        for (int k = 0; k < NUM_PORTS; k++)
            gap[k] = 0;
        for (int c = 0; c < n_cycles; c++)
        begin
            @(posedge clk);
            in_valid <= '0;
            for (int k = 0; k < NUM_PORTS; k++)
            begin
                if (gap[k] > 0)
                    gap[k]--;
                else if (!in_full[k])
                begin
                    draw(4, r);
                    drive_flit(k, r[3:2], r[1:0]);
                    draw(2, r);
                    gap[k] = int'(r[1:0]);
                end
            end
        end
        @(posedge clk);
        in_valid <= '0;
        wait_drain(DRAIN_LIMIT);
    endtask

    task automatic fairness();
        apply_reset();
        clear_log();
        @(posedge clk);
        for (int k = 0; k < NUM_PORTS; k++)
            drive_flit(k, MY_X, MY_Y);
        @(posedge clk);
        in_valid <= '0;
        wait_drain(50);
        check_eq("local arrivals", arr_port.size(), NUM_PORTS);
        if (arr_port.size() == NUM_PORTS)
        begin
            for (int i = 0; i < NUM_PORTS; i++)
            begin
                check_eq("out port", arr_port[i], int'(DIR_LOCAL));
                check_eq("grant source", arr_src[i], i);
                check_eq("grant cycle", arr_cyc[i], arr_cyc[0] + i);
            end
        end
    endtask

    // Everyone floods the east output, writes go out regardless of in_full
    task automatic overflow();
        full_seen = 1'b0;
        for (int c = 0; c < 40; c++)
        begin
            @(posedge clk);
            for (int k = 0; k < NUM_PORTS; k++)
                drive_flit(k, 2'd2, MY_Y);
        end
        @(posedge clk);
        in_valid <= '0;
        wait_drain(DRAIN_LIMIT);
        checks++;
        assert (full_seen)
        else
        begin
            $display("%0t: no input reported full during the flood", $time);
            errors++;
        end
    endtask

    initial
    begin
        clk      = 1'b0;
        rst_n    = 1'b1;
        in_valid = '0;
        in_flit  = '0;
        lfsr     = 32'ha543_3346;
        pending  = 0;
        acc_cyc  = 0;
        checks   = 0;
        errors   = 0;
        err_mark = 0;
        for (int k = 0; k < NUM_PORTS; k++)
            seq[k] = '0;

        // Reset held for two cycles, outputs checked during and after
        repeat (2)
        begin
            @(negedge clk);
            check_eq("out_valid", out_valid, '0);
            check_eq("in_full", in_full, '0);
        end
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (2)
        begin
            @(negedge clk);
            check_eq("out_valid", out_valid, '0);
            check_eq("in_full", in_full, '0);
        end
        report(1, "reset state");

        single_flits();
        report(2, "latency and routing");
        random_traffic(400);
        report(3, "random traffic");
        fairness();
        report(4, "round-robin order");
        overflow();
        report(5, "full and drop");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
hdl/router_pkg.sv
hdl/port_req_if.sv
hdl/flit_fifo.sv
hdl/input_unit.sv
hdl/output_port.sv
hdl/router_top.sv
test/router_tb.sv

// ==== Makefile ====
# Verilator build and run of the router testbench

LOG := sim.log

.PHONY: all lint clean

all:
	verilator --binary --assert -f list.f --top-module router_tb -Mdir obj_dir -o router_sim
	./obj_dir/router_sim | tee $(LOG)
	@if grep -q "test failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "test passed" $(LOG)

lint:
	verilator --lint-only --timing -f list.f --top-module router_tb

clean:
	rm -rf obj_dir $(LOG)
